// ==== cpu_pkg.sv ====
package cpu_pkg;

    // byte address on the fetch path
    typedef logic [31:0] addr_t;

    // fixed-width instructions
    localparam int INSTR_BYTES = 4;

    // the two instruction slots looked up each fetch cycle
    typedef enum logic {
        SLOT_PC   = 1'b0,
        SLOT_PCP4 = 1'b1
    } slot_t;

endpackage

// ==== pred_pkg.sv ====
package pred_pkg;

    import cpu_pkg::*;

    // return-pc table geometry
    localparam int SET_NUM       = 8;
    localparam int ASSOCIATIVITY = 2;
    localparam int INDEX_BITS    = $clog2(SET_NUM);
    // pc bits 1:0 never reach the table
    localparam int TAG_BITS      = 30 - INDEX_BITS;

    // return address stack
    localparam int RAS_DEPTH     = 8;
    localparam int RAS_PTR_BITS  = $clog2(RAS_DEPTH);
    localparam int RAS_CNT_BITS  = $clog2(RAS_DEPTH + 1);

    // training queue, also the sender's credit pool
    localparam int QUEUE_DEPTH    = 4;
    localparam int QUEUE_PTR_BITS = $clog2(QUEUE_DEPTH);

    typedef logic [TAG_BITS-1:0]   tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;

    // one way of one set
    typedef struct packed {
        logic valid;
        tag_t tag;
    } meta_t;

    // one memory row holds every way of a set
    typedef meta_t [ASSOCIATIVITY-1:0] meta_set_t;

    typedef enum logic {
        TRAIN_CALL   = 1'b0,
        TRAIN_RETURN = 1'b1
    } train_kind_t;

    // link is only meaningful for calls
    typedef struct packed {
        train_kind_t kind;
        addr_t       pc;
        addr_t       link;
    } train_rec_t;

    typedef struct packed {
        logic  hit;
        logic  hit_pc;
        logic  hit_pcp4;
        addr_t target;
    } pred_out_t;

    function automatic tag_t pc_tag(addr_t pc);
        return pc[31:2+INDEX_BITS];
    endfunction

    function automatic index_t pc_index(addr_t pc);
        return pc[2+INDEX_BITS-1:2];
    endfunction

endpackage

// ==== lutram_dual_port.sv ====
`timescale 1ns/1ps

module lutram_dual_port
    import pred_pkg::*;
(
    input  logic      clk,
    input  logic      we,
    input  index_t    waddr,
    input  meta_set_t wdata,
    input  index_t    raddr_a,
    input  index_t    raddr_b,
    output meta_set_t rdata_a,
    output meta_set_t rdata_b
);

    // one row per set, every way side by side
    meta_set_t mem [SET_NUM];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // reads see the old row until the write edge
    assign rdata_a = mem[raddr_a];
    assign rdata_b = mem[raddr_b];

endmodule

// ==== rpct.sv ====
`timescale 1ns/1ps

module rpct
    import cpu_pkg::*;
    import pred_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  is_write,
    input  addr_t write_pc,
    input  addr_t lookup_pc,
    output logic  ready,
    output logic  hit,
    output logic  hit_pc,
    output logic  hit_pcp4
);

    addr_t     pcp4;
    index_t    lookup_idx;
    index_t    pcp4_idx;
    index_t    write_idx;
    tag_t      lookup_tag;
    tag_t      pcp4_tag;
    tag_t      write_tag;

    meta_set_t row_a;
    meta_set_t row_b;
    meta_set_t wr_row;
    meta_set_t mem_wdata;
    index_t    mem_waddr;
    index_t    raddr_a;
    logic      mem_we;

    logic      sweeping;
    index_t    sweep_idx;

    logic      pc_match;
    logic      pcp4_match;
    logic      pc_way;
    logic      pcp4_way;
    logic      wr_match;
    logic      wr_match_way;
    logic      wr_free;
    logic      wr_free_way;
    logic      wr_way;

    slot_t     upd_slot;
    index_t    upd_idx;
    logic      upd_way;
    // one bit per set names the victim way
    logic [SET_NUM-1:0] plru;

    assign pcp4       = lookup_pc + INSTR_BYTES;
    assign lookup_idx = pc_index(lookup_pc);
    assign lookup_tag = pc_tag(lookup_pc);
    assign pcp4_idx   = pc_index(pcp4);
    assign pcp4_tag   = pc_tag(pcp4);
    assign write_idx  = pc_index(write_pc);
    assign write_tag  = pc_tag(write_pc);

    // port a serves the write, otherwise the plus-4 slot
    assign raddr_a = is_write ? write_idx : pcp4_idx;

    always_comb begin
        pc_match   = 1'b0;
        pc_way     = 1'b0;
        pcp4_match = 1'b0;
        pcp4_way   = 1'b0;
        for (int i = 0; i < ASSOCIATIVITY; i++) begin
            if (row_b[i].valid && (row_b[i].tag == lookup_tag)) begin
                pc_match = 1'b1;
                pc_way   = 1'(i);
            end
            if (row_a[i].valid && (row_a[i].tag == pcp4_tag)) begin
                pcp4_match = 1'b1;
                pcp4_way   = 1'(i);
            end
        end
    end

    // table contents are not trusted until the sweep is done
    assign hit_pc   = ready & pc_match;
    assign hit_pcp4 = ready & ~is_write & pcp4_match;
    assign hit      = hit_pc | hit_pcp4;

    // way choice: same tag, then a free way, then the plru victim
    always_comb begin
        wr_match     = 1'b0;
        wr_match_way = 1'b0;
        wr_free      = 1'b0;
        wr_free_way  = 1'b0;
        for (int i = 0; i < ASSOCIATIVITY; i++) begin
            if (row_a[i].valid && (row_a[i].tag == write_tag)) begin
                wr_match     = 1'b1;
                wr_match_way = 1'(i);
            end
            if (!row_a[i].valid && !wr_free) begin
                wr_free     = 1'b1;
                wr_free_way = 1'(i);
            end
        end
        if (wr_match) begin
            wr_way = wr_match_way;
        end else if (wr_free) begin
            wr_way = wr_free_way;
        end else begin
            wr_way = plru[write_idx];
        end
        wr_row               = row_a;
        wr_row[wr_way].valid = 1'b1;
        wr_row[wr_way].tag   = write_tag;
    end

    // sweep owns the write port while it runs
    assign mem_we    = sweeping | is_write;
    assign mem_waddr = sweeping ? sweep_idx : write_idx;
    assign mem_wdata = sweeping ? '0 : wr_row;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sweeping  <= 1'b1;
            sweep_idx <= '0;
        end else if (sweeping) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (sweep_idx == index_t'(SET_NUM - 1)) begin
                sweeping <= 1'b0;
            end
        end
    end

    assign ready = ~sweeping;

    // fetch-pc slot wins when both hit
    assign upd_slot = pc_match ? SLOT_PC : SLOT_PCP4;
    assign upd_idx  = (upd_slot == SLOT_PC) ? lookup_idx : pcp4_idx;
    assign upd_way  = (upd_slot == SLOT_PC) ? pc_way : pcp4_way;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            plru <= '0;
        end else if (hit) begin
            // the other way becomes the victim
            plru[upd_idx] <= ~upd_way;
        end
    end

    lutram_dual_port meta_ram (
        .clk     (clk),
        .we      (mem_we),
        .waddr   (mem_waddr),
        .wdata   (mem_wdata),
        .raddr_a (raddr_a),
        .raddr_b (lookup_idx),
        .rdata_a (row_a),
        .rdata_b (row_b)
    );

endmodule

// ==== ras.sv ====
`timescale 1ns/1ps

module ras
    import cpu_pkg::*;
    import pred_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  push,
    input  logic  pop,
    input  addr_t push_addr,
    output addr_t top,
    output logic  empty
);

    addr_t stack [RAS_DEPTH];

    // ptr points at the current top entry
    logic [RAS_PTR_BITS-1:0] ptr;
    logic [RAS_CNT_BITS-1:0] count;
    logic                    full;
    logic                    replace;
    logic                    do_push;
    logic                    do_pop;

    assign empty = (count == '0);
    assign full  = (count == RAS_CNT_BITS'(RAS_DEPTH));

    // push with pop swaps the top in place
    assign replace = push & pop & ~empty;
    assign do_push = push & ~replace;
    assign do_pop  = pop & ~push & ~empty;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr   <= '0;
            count <= '0;
        end else if (do_push) begin
            // wrapping onto the oldest entry when full
            ptr <= ptr + 1'b1;
            if (!full) begin
                count <= count + 1'b1;
            end
        end else if (do_pop) begin
            ptr   <= ptr - 1'b1;
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (replace) begin
            stack[ptr] <= push_addr;
        end else if (do_push) begin
            stack[ptr + 1'b1] <= push_addr;
        end
    end

    assign top = empty ? '0 : stack[ptr];

endmodule

// ==== update_queue.sv ====
`timescale 1ns/1ps

module update_queue
    import pred_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       train_valid,
    input  train_rec_t train_rec,
    input  logic       apply,
    output train_rec_t head,
    output logic       head_valid,
    output logic       train_credit
);

    train_rec_t mem [QUEUE_DEPTH];

    // extra msb tells full from empty
    logic [QUEUE_PTR_BITS:0] wr_ptr;
    logic [QUEUE_PTR_BITS:0] rd_ptr;
    logic                    deq;

    assign head_valid = (wr_ptr != rd_ptr);
    assign head       = mem[rd_ptr[QUEUE_PTR_BITS-1:0]];
    assign deq        = apply & head_valid;

    // the sender holds a credit for every slot it fills
    always_ff @(posedge clk) begin
        if (train_valid) begin
            mem[wr_ptr[QUEUE_PTR_BITS-1:0]] <= train_rec;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (train_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // one credit back per dequeued record
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            train_credit <= 1'b0;
        end else begin
            train_credit <= deq;
        end
    end

endmodule

// ==== return_predictor.sv ====
`timescale 1ns/1ps

module return_predictor
    import cpu_pkg::*;
    import pred_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       train_valid,
    input  train_rec_t train_rec,
    input  addr_t      fetch_pc,
    output logic       train_credit,
    output pred_out_t  pred
);

    train_rec_t head;
    logic       head_valid;
    logic       apply;
    logic       ready;
    logic       ret_apply;
    logic       call_apply;
    logic       rpct_hit;
    logic       rpct_hit_pc;
    logic       rpct_hit_pcp4;
    addr_t      ras_top;

    // records stall in the queue during the sweep
    assign apply      = head_valid & ready;
    assign ret_apply  = apply & (head.kind == TRAIN_RETURN);
    assign call_apply = apply & (head.kind == TRAIN_CALL);

    update_queue u_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .train_valid  (train_valid),
        .train_rec    (train_rec),
        .apply        (apply),
        .head         (head),
        .head_valid   (head_valid),
        .train_credit (train_credit)
    );

    // a return both trains the table and retires the stack top
    rpct u_rpct (
        .clk       (clk),
        .rst_n     (rst_n),
        .is_write  (ret_apply),
        .write_pc  (head.pc),
        .lookup_pc (fetch_pc),
        .ready     (ready),
        .hit       (rpct_hit),
        .hit_pc    (rpct_hit_pc),
        .hit_pcp4  (rpct_hit_pcp4)
    );

    ras u_ras (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (call_apply),
        .pop       (ret_apply),
        .push_addr (head.link),
        .top       (ras_top),
        .empty     ()
    );

    // target only means something alongside hit
    assign pred = '{
        hit:      rpct_hit,
        hit_pc:   rpct_hit_pc,
        hit_pcp4: rpct_hit_pcp4,
        target:   ras_top
    };

endmodule

// ==== rpct_checker.sv ====
`timescale 1ns/1ps

module rpct_checker
    import cpu_pkg::*;
    import pred_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      train_valid,
    input  logic      train_credit,
    input  addr_t     fetch_pc,
    input  pred_out_t pred,
    input  logic      check_en,
    input  logic      exp_hit_pc,
    input  logic      exp_hit_pcp4,
    input  addr_t     exp_target,
    input  logic      final_check,
    output int        pass_count,
    output int        fail_count
);

    int   passes = 0;
    int   fails = 0;
    int   lookup_num = 0;
    // records sent whose credit has not come back yet
    int   in_flight = 0;
    logic exp_hit;

    assign exp_hit    = exp_hit_pc | exp_hit_pcp4;
    assign pass_count = passes;
    assign fail_count = fails;

    task automatic check_lookup();
        lookup_num++;
        if (pred.hit_pc !== exp_hit_pc) begin
            $display("[FAIL] lookup %0d pc %h: hit_pc expected %h got %h",
                     lookup_num, fetch_pc, exp_hit_pc, pred.hit_pc);
            fails++;
        end else if (pred.hit_pcp4 !== exp_hit_pcp4) begin
            $display("[FAIL] lookup %0d pc %h: hit_pcp4 expected %h got %h",
                     lookup_num, fetch_pc, exp_hit_pcp4, pred.hit_pcp4);
            fails++;
        end else if (pred.hit !== exp_hit) begin
            $display("[FAIL] lookup %0d pc %h: hit expected %h got %h",
                     lookup_num, fetch_pc, exp_hit, pred.hit);
            fails++;
        end else if (exp_hit && pred.target !== exp_target) begin
            $display("[FAIL] lookup %0d pc %h: target expected %h got %h",
                     lookup_num, fetch_pc, exp_target, pred.target);
            fails++;
        end else begin
            $display("[PASS] lookup %0d pc %h", lookup_num, fetch_pc);
            passes++;
        end
    endtask

    task automatic check_credits();
        if (in_flight != 0) begin
            $display("[FAIL] credits: outstanding expected %h got %h", 0, in_flight);
            fails++;
        end else begin
            $display("[PASS] credits: all %0d returned", QUEUE_DEPTH);
            passes++;
        end
    endtask

    // sampled mid-cycle since inputs settle 1 ns after the edge
    always @(negedge clk) begin
        if (!rst_n) begin
            in_flight = 0;
        end else begin
            if (train_valid && in_flight >= QUEUE_DEPTH) begin
                $display("error: training record sent while no credit was left");
                fails++;
            end
            // a record sent this cycle is not yet in the queue
            if (train_credit && in_flight == 0) begin
                $display("error: credit returned while no training record was outstanding");
                fails++;
            end
            in_flight = in_flight + int'(train_valid) - int'(train_credit);
        end
        if (check_en) begin
            check_lookup();
        end
        if (final_check) begin
            check_credits();
        end
    end

endmodule

// ==== tb_top.sv ====
`timescale 1ns/1ps

module tb_top
    import cpu_pkg::*;
    import pred_pkg::*;
();

    localparam int    WAIT_LIMIT = 200;
    // fetch address that never matches a trained return
    localparam addr_t IDLE_PC    = 32'hffff_fff0;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       train_valid;
    train_rec_t train_rec;
    addr_t      fetch_pc;
    logic       train_credit;
    pred_out_t  pred;

    logic       check_en;
    logic       exp_hit_pc;
    logic       exp_hit_pcp4;
    addr_t      exp_target;
    logic       final_check;
    int         pass_count;
    int         fail_count;

    int         sent_count = 0;
    int         returned_count = 0;
    logic       aborted;

    always #2 clk = ~clk;

    // one credit per pulse
    always @(negedge clk) begin
        if (train_credit) begin
            returned_count = returned_count + 1;
        end
    end

    function automatic int credits_left();
        return QUEUE_DEPTH - (sent_count - returned_count);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_for_credit();
        int cycles;
        cycles = 0;
        while (credits_left() == 0 && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (credits_left() == 0) begin
            $display("timeout: no training credit came back within %0d cycles", WAIT_LIMIT);
            aborted = 1'b1;
        end
    endtask

    // all records applied once every credit is home
    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (credits_left() != QUEUE_DEPTH && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (credits_left() != QUEUE_DEPTH) begin
            $display("timeout: training queue did not drain within %0d cycles", WAIT_LIMIT);
            aborted = 1'b1;
        end
    endtask

    task automatic send_record(train_kind_t kind, addr_t pc, addr_t link);
        int gap;
        wait_for_credit();
        if (!aborted) begin
            train_valid = 1'b1;
            train_rec   = '{kind: kind, pc: pc, link: link};
            sent_count++;
            next_cycle();
            train_valid = 1'b0;
            gap = int'($urandom % 3);
            repeat (gap) next_cycle();
        end
    endtask

    task automatic run_lookup(addr_t pc, logic e_pc, logic e_pcp4, addr_t e_tgt);
        wait_for_drain();
        if (!aborted) begin
            fetch_pc     = pc;
            exp_hit_pc   = e_pc;
            exp_hit_pcp4 = e_pcp4;
            exp_target   = e_tgt;
            check_en     = 1'b1;
            next_cycle();
            check_en     = 1'b0;
            fetch_pc     = IDLE_PC;
        end
    endtask

    initial begin
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op;
        addr_t       f_pc;
        addr_t       f_link;
        addr_t       f_tgt;
        logic [31:0] f_hit_pc;
        logic [31:0] f_hit_pcp4;

        rst_n        = 1'b0;
        train_valid  = 1'b0;
        train_rec    = '0;
        fetch_pc     = IDLE_PC;
        check_en     = 1'b0;
        exp_hit_pc   = 1'b0;
        exp_hit_pcp4 = 1'b0;
        exp_target   = '0;
        final_check  = 1'b0;
        aborted      = 1'b0;
        void'($urandom(51584));

        fd = $fopen("rpct_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file rpct_stim.txt");
            aborted = 1'b1;
        end

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        while (!aborted && $fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%c %h %h %h %h %h",
                        op, f_pc, f_link, f_hit_pc, f_hit_pcp4, f_tgt);
            if (n != 6) begin
                $display("malformed stimulus line: %s", line);
                aborted = 1'b1;
            end else begin
                case (op)
                    "C": send_record(TRAIN_CALL, f_pc, f_link);
                    "R": send_record(TRAIN_RETURN, f_pc, f_link);
                    "L": run_lookup(f_pc, f_hit_pc[0], f_hit_pcp4[0], f_tgt);
                    "W": repeat (f_pc) next_cycle();
                    default: begin
                        $display("unknown opcode in stimulus line: %s", line);
                        aborted = 1'b1;
                    end
                endcase
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        wait_for_drain();
        final_check = 1'b1;
        next_cycle();
        final_check = 1'b0;
        next_cycle();

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (!aborted && fail_count == 0 && pass_count > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    return_predictor uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .train_valid  (train_valid),
        .train_rec    (train_rec),
        .fetch_pc     (fetch_pc),
        .train_credit (train_credit),
        .pred         (pred)
    );

    rpct_checker u_check (
        .clk          (clk),
        .rst_n        (rst_n),
        .train_valid  (train_valid),
        .train_credit (train_credit),
        .fetch_pc     (fetch_pc),
        .pred         (pred),
        .check_en     (check_en),
        .exp_hit_pc   (exp_hit_pc),
        .exp_hit_pcp4 (exp_hit_pcp4),
        .exp_target   (exp_target),
        .final_check  (final_check),
        .pass_count   (pass_count),
        .fail_count   (fail_count)
    );

endmodule

// ==== rpct_stim.txt ====
# op pc link exp_hit_pc exp_hit_pcp4 exp_target, all hex
# op is C call, R return, L lookup, W wait (pc column holds the cycle count)
W 0000000c 00000000 0 0 00000000
# empty table once the sweep is done
L 00001000 00000000 0 0 00000000
L 00000040 00000000 0 0 00000000
# one return in set 2, seen from the pc slot and the plus-4 slot
R 00001008 00000000 0 0 00000000
L 00001008 00000000 1 0 00000000
L 00001004 00000000 0 1 00000000
# set 5 fills with 2014 and 3014, the hit on 2014 leaves 3014 as victim
R 00002014 00000000 0 0 00000000
R 00003014 00000000 0 0 00000000
L 00002014 00000000 1 0 00000000
R 00004014 00000000 0 0 00000000
L 00003014 00000000 0 0 00000000
L 00002014 00000000 1 0 00000000
L 00004014 00000000 1 0 00000000
# nested calls, then each return pops one link
C 00005000 00005004 0 0 00000000
C 00006000 00006004 0 0 00000000
C 00007000 00007004 0 0 00000000
L 00001008 00000000 1 0 00007004
R 00008010 00000000 0 0 00000000
L 00008010 00000000 1 0 00006004
R 00008010 00000000 0 0 00000000
L 00008010 00000000 1 0 00005004
R 00008010 00000000 0 0 00000000
L 00008010 00000000 1 0 00000000

// ==== Makefile ====
TOP = tb_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f files.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== files.f ====
cpu_pkg.sv
pred_pkg.sv
lutram_dual_port.sv
rpct.sv
ras.sv
update_queue.sv
return_predictor.sv
rpct_checker.sv
tb_top.sv
